/* source/rv32i_types_pkg.sv */
// Shared widths and memory-operation encoding for the RV32I load/store unit.
// Every module of the unit takes what it needs from here by scoped name.
`default_nettype none

package rv32i_types_pkg;

  // ########################################
  // Widths
  // ########################################

  // Data path and address width of the core.
  localparam int unsigned xlen = 32;

  // Word-address bits of the data RAM; 8 bits give 256 words, or 1 KiB.
  localparam int unsigned ram_addr_w = 8;

  // ########################################
  // Memory operations
  // ########################################

  // One type names both loads and stores, as on the core's memory port.
  // The byte and halfword loads come in signed and unsigned flavours.
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LH  = 3'd1,
    LW  = 3'd2,
    LBU = 3'd3,
    LHU = 3'd4,
    SB  = 3'd5,
    SH  = 3'd6,
    SW  = 3'd7
  } load_t;

endpackage

`default_nettype wire

/* source/agu.sv */
// Address generation unit.
// Adds the operands, picks the byte lanes and flags misaligned accesses.
`timescale 1ns/1ps
`default_nettype none

module agu (
  input  wire logic [rv32i_types_pkg::xlen-1:0] port_a,
  input  wire logic [rv32i_types_pkg::xlen-1:0] port_b,
  input  wire rv32i_types_pkg::load_t           load_type,
  output logic      [3:0]                       byte_en,
  output logic      [rv32i_types_pkg::xlen-1:0] address,
  output logic                                  mal_addr
);

  logic [1:0] byte_offset;
  logic [3:0] lane_en;
  logic       misaligned;

  // Effective address is base plus offset, with no carry-out kept.
  assign address     = port_a + port_b;
  assign byte_offset = address[1:0];

  // ########################################
  // Lane selection
  // ########################################

  // The access width comes from the operation; the low address bits
  // say where inside the word the access lands.
  always_comb begin
    lane_en    = 4'b0000;
    misaligned = 1'b0;
    case (load_type)
      rv32i_types_pkg::LB,
      rv32i_types_pkg::LBU,
      rv32i_types_pkg::SB: begin
        // A byte is always aligned and owns exactly one lane.
        lane_en = 4'b0001 << byte_offset;
      end
      rv32i_types_pkg::LH,
      rv32i_types_pkg::LHU,
      rv32i_types_pkg::SH: begin
        // Bit 1 picks the upper or lower pair.
        // An odd offset would straddle two pairs.
        lane_en    = byte_offset[1] ? 4'b1100 : 4'b0011;
        misaligned = byte_offset[0];
      end
      rv32i_types_pkg::LW,
      rv32i_types_pkg::SW: begin
        // Words must sit on a word boundary.
        lane_en    = 4'b1111;
        misaligned = (byte_offset != 2'b00);
      end
      default: begin
        lane_en    = 4'b0000;
        misaligned = 1'b0;
      end
    endcase
  end

  // ########################################
  // Outputs
  // ########################################

  // A misaligned access touches no lane at all, so nothing downstream
  // can write a partial word by accident.
  assign mal_addr = misaligned;
  assign byte_en  = misaligned ? 4'b0000 : lane_en;

endmodule

`default_nettype wire

/* source/store_align.sv */
// Store data alignment.
// Replicates the store byte or halfword across the lanes of the write word.
`timescale 1ns/1ps
`default_nettype none

module store_align (
  input  wire logic [rv32i_types_pkg::xlen-1:0] store_data,
  input  wire logic [rv32i_types_pkg::xlen-1:0] address,
  input  wire rv32i_types_pkg::load_t           load_type,
  output logic      [rv32i_types_pkg::xlen-1:0] wdata
);

  logic [rv32i_types_pkg::xlen-1:0] rep_data;
  logic [3:0]                       lane_hit;

  // Replication puts the value in every lane it could land in.
  // The RAM byte enables then decide which of them is really stored.
  always_comb begin
    case (load_type)
      rv32i_types_pkg::SB: rep_data = {4{store_data[7:0]}};
      rv32i_types_pkg::SH: rep_data = {2{store_data[15:0]}};
      rv32i_types_pkg::SW: rep_data = store_data;
      default:             rep_data = '0;
    endcase
  end

  // Lanes that the store does not address are driven to zero.
  // The write bus then only toggles where a byte is actually stored.
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      case (load_type)
        rv32i_types_pkg::SB: lane_hit[i] = (address[1:0] == 2'(i));
        rv32i_types_pkg::SH: lane_hit[i] = (address[1] == (i >= 2));
        rv32i_types_pkg::SW: lane_hit[i] = 1'b1;
        default:             lane_hit[i] = 1'b0;
      endcase
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      wdata[8*i +: 8] = lane_hit[i] ? rep_data[8*i +: 8] : 8'h00;
    end
  end

endmodule

`default_nettype wire

/* source/access_ctrl.sv */
// Access control for the load/store unit.
// Drives the RAM strobes and registers the load and fault responses.
`timescale 1ns/1ps
`default_nettype none

module access_ctrl (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic                             req,
  input  wire rv32i_types_pkg::load_t           load_type,
  input  wire logic [rv32i_types_pkg::xlen-1:0] address,
  input  wire logic                             mal_addr,
  output logic                                  we,
  output logic                                  re,
  output logic                                  load_valid,
  output logic                                  fault,
  output logic      [rv32i_types_pkg::xlen-1:0] fault_addr,
  output rv32i_types_pkg::load_t                load_type_q,
  output logic      [1:0]                       offset_q
);

  logic is_load;
  logic is_store;

  // Split the operation space into its two classes.
  always_comb begin
    is_load  = 1'b0;
    is_store = 1'b0;
    case (load_type)
      rv32i_types_pkg::LB, rv32i_types_pkg::LH, rv32i_types_pkg::LW,
      rv32i_types_pkg::LBU, rv32i_types_pkg::LHU: is_load = 1'b1;
      rv32i_types_pkg::SB, rv32i_types_pkg::SH, rv32i_types_pkg::SW: is_store = 1'b1;
      default: begin
        is_load  = 1'b0;
        is_store = 1'b0;
      end
    endcase
  end

  // A misaligned request never reaches the RAM.
  assign we = req && is_store && !mal_addr;
  assign re = req && is_load && !mal_addr;

  // ########################################
  // Response registers
  // ########################################

  // Pulses last exactly one cycle after the request.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_valid <= 1'b0;
      fault      <= 1'b0;
    end else begin
      load_valid <= re;
      fault      <= req && mal_addr;
    end
  end

  // Load context and faulting address ride along with the pulses.
  always_ff @(posedge clk) begin
    if (re) begin
      load_type_q <= load_type;
      offset_q    <= address[1:0];
    end
    if (req && mal_addr) begin
      fault_addr <= address;
    end
  end

  // The RAM port is either written or read in a cycle, never both.
  a_we_re_excl : assert property (@(posedge clk) disable iff (!rst_n) !(we && re));

  // No write lands on an address that is off the boundary of its own width.
  a_no_mal_write : assert property (@(posedge clk) disable iff (!rst_n)
    we |-> !((load_type == rv32i_types_pkg::SH && address[0]) ||
             (load_type == rv32i_types_pkg::SW && address[1:0] != 2'b00)));

  // The address unit may only flag an access whose low bits are nonzero.
  a_mal_offset : assert property (@(posedge clk) disable iff (!rst_n)
    mal_addr |-> (address[1:0] != 2'b00));

endmodule

`default_nettype wire

/* source/data_ram.sv */
// Data RAM of the load/store unit.
// One word wide, byte-enabled writes and a registered read port.
`timescale 1ns/1ps
`default_nettype none

module data_ram (
  input  wire logic                                   clk,
  input  wire logic                                   we,
  input  wire logic                                   re,
  input  wire logic [3:0]                             byte_en,
  input  wire logic [rv32i_types_pkg::ram_addr_w-1:0] word_addr,
  input  wire logic [rv32i_types_pkg::xlen-1:0]       wdata,
  output logic      [rv32i_types_pkg::xlen-1:0]       rdata
);

  // ########################################
  // Storage
  // ########################################

  // 256 words; contents come up undefined after power-on.
  logic [rv32i_types_pkg::xlen-1:0] mem [2**rv32i_types_pkg::ram_addr_w];

  // Each lane has its own write enable.
  // Lanes that are not enabled keep their old value.
  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_en[i]) begin
          mem[word_addr][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  // ########################################
  // Read port
  // ########################################

  // The read word appears in the cycle after re.
  // It holds its value while no read is issued.
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[word_addr];
    end
  end

  // A write with no lane enabled means the misalignment gate failed upstream.
  a_we_lanes : assert property (@(posedge clk) we |-> (byte_en != 4'b0000));

endmodule

`default_nettype wire

/* source/load_align.sv */
// Load data alignment.
// Picks the addressed byte or halfword from the read word and extends it.
`timescale 1ns/1ps
`default_nettype none

module load_align (
  input  wire logic [rv32i_types_pkg::xlen-1:0] rdata,
  input  wire rv32i_types_pkg::load_t           load_type_q,
  input  wire logic [1:0]                       offset_q,
  output logic      [rv32i_types_pkg::xlen-1:0] load_data
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // ########################################
  // Lane extraction
  // ########################################

  // The byte offset from the request cycle selects one of four lanes.
  always_comb begin
    case (offset_q)
      2'b00:   byte_sel = rdata[7:0];
      2'b01:   byte_sel = rdata[15:8];
      2'b10:   byte_sel = rdata[23:16];
      default: byte_sel = rdata[31:24];
    endcase
  end

  // Halfwords are aligned, so only bit 1 of the offset matters.
  assign half_sel = offset_q[1] ? rdata[31:16] : rdata[15:0];

  // ########################################
  // Extension
  // ########################################

  // Signed loads copy the top bit of the selected field upward.
  // Unsigned loads fill with zeros.
  always_comb begin
    case (load_type_q)
      rv32i_types_pkg::LB:
        load_data = {{(rv32i_types_pkg::xlen-8){byte_sel[7]}}, byte_sel};
      rv32i_types_pkg::LBU:
        load_data = {{(rv32i_types_pkg::xlen-8){1'b0}}, byte_sel};
      rv32i_types_pkg::LH:
        load_data = {{(rv32i_types_pkg::xlen-16){half_sel[15]}}, half_sel};
      rv32i_types_pkg::LHU:
        load_data = {{(rv32i_types_pkg::xlen-16){1'b0}}, half_sel};
      rv32i_types_pkg::LW:
        load_data = rdata;
      // Stores never produce a load result.
      default:
        load_data = '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/lsu_top.sv */
// Load/store unit top level.
// Connects address generation, alignment, access control and the data RAM.
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic                             req,
  input  wire logic [rv32i_types_pkg::xlen-1:0] port_a,
  input  wire logic [rv32i_types_pkg::xlen-1:0] port_b,
  input  wire rv32i_types_pkg::load_t           load_type,
  input  wire logic [rv32i_types_pkg::xlen-1:0] store_data,
  output logic                                  load_valid,
  output logic      [rv32i_types_pkg::xlen-1:0] load_data,
  output logic                                  fault,
  output logic      [rv32i_types_pkg::xlen-1:0] fault_addr
);

  // ########################################
  // Internal wiring
  // ########################################

  logic [rv32i_types_pkg::xlen-1:0] address;
  logic [3:0]                       byte_en;
  logic                             mal_addr;
  logic [rv32i_types_pkg::xlen-1:0] wdata;
  logic [rv32i_types_pkg::xlen-1:0] rdata;
  logic                             we;
  logic                             re;
  rv32i_types_pkg::load_t           load_type_q;
  logic [1:0]                       offset_q;

  // Request cycle: address, lanes and write data are all combinational.
  agu u_agu (
    .port_a    (port_a),
    .port_b    (port_b),
    .load_type (load_type),
    .byte_en   (byte_en),
    .address   (address),
    .mal_addr  (mal_addr)
  );

  store_align u_store_align (
    .store_data (store_data),
    .address    (address),
    .load_type  (load_type),
    .wdata      (wdata)
  );

  access_ctrl u_access_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .load_type   (load_type),
    .address     (address),
    .mal_addr    (mal_addr),
    .we          (we),
    .re          (re),
    .load_valid  (load_valid),
    .fault       (fault),
    .fault_addr  (fault_addr),
    .load_type_q (load_type_q),
    .offset_q    (offset_q)
  );

  // Address bits above bit 9 are dropped, so higher addresses alias.
  data_ram u_data_ram (
    .clk       (clk),
    .we        (we),
    .re        (re),
    .byte_en   (byte_en),
    .word_addr (address[rv32i_types_pkg::ram_addr_w+1:2]),
    .wdata     (wdata),
    .rdata     (rdata)
  );

  // Response cycle: the registered context shapes the read word.
  load_align u_load_align (
    .rdata       (rdata),
    .load_type_q (load_type_q),
    .offset_q    (offset_q),
    .load_data   (load_data)
  );

endmodule

`default_nettype wire

/* testbench/clk_gen.sv */
// Clock and reset source for the load/store unit testbench.
// 20 ns clock, reset held low for the first ten cycles.
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk,
  output logic rst_n
);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Reset is released on a falling edge, away from the sampling edge.
  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/lsu_tb.sv */
// Random-stimulus testbench for the load/store unit.
// A byte-array model predicts every load and fault one cycle ahead.
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

  localparam int n_init     = 16;
  localparam int n_rand     = 400;
  localparam int timeout_ns = (n_init + n_rand) * 20 + 200 * 20;
  localparam int kind_none  = 0;
  localparam int kind_load  = 1;
  localparam int kind_fault = 2;

  logic                             clk;
  logic                             rst_n;
  logic                             req;
  logic [rv32i_types_pkg::xlen-1:0] port_a;
  logic [rv32i_types_pkg::xlen-1:0] port_b;
  rv32i_types_pkg::load_t           load_type;
  logic [rv32i_types_pkg::xlen-1:0] store_data;
  logic                             load_valid;
  logic [rv32i_types_pkg::xlen-1:0] load_data;
  logic                             fault;
  logic [rv32i_types_pkg::xlen-1:0] fault_addr;

  // Reference memory, one entry per byte of the 1 KiB RAM.
  logic [7:0]                       model_mem [1024];
  // Expected response for each driven cycle, oldest first.
  int                               kind_q [$];
  logic [rv32i_types_pkg::xlen-1:0] val_q [$];
  rv32i_types_pkg::load_t           op_q [$];
  int                               data_errors;
  int                               pulse_errors;

  clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  lsu_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .port_a     (port_a),
    .port_b     (port_b),
    .load_type  (load_type),
    .store_data (store_data),
    .load_valid (load_valid),
    .load_data  (load_data),
    .fault      (fault),
    .fault_addr (fault_addr)
  );

  // ########################################
  // Reference model
  // ########################################

  // Halfwords need an even offset, words a zero offset; bytes always fit.
  function automatic logic is_mal(rv32i_types_pkg::load_t op, logic [1:0] off);
    case (op)
      rv32i_types_pkg::LH, rv32i_types_pkg::LHU, rv32i_types_pkg::SH: return off[0];
      rv32i_types_pkg::LW, rv32i_types_pkg::SW: return off != 2'b00;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic is_load_op(rv32i_types_pkg::load_t op);
    case (op)
      rv32i_types_pkg::SB, rv32i_types_pkg::SH, rv32i_types_pkg::SW: return 1'b0;
      default: return 1'b1;
    endcase
  endfunction

  // Only address bits 9..0 reach the RAM, so upper bits alias.
  function automatic logic [31:0] model_read(logic [31:0] addr, rv32i_types_pkg::load_t op);
    logic [9:0]  base;
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] w;
    base = {addr[9:2], 2'b00};
    w = {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
    b = model_mem[addr[9:0]];
    h = {model_mem[{addr[9:1], 1'b1}], model_mem[{addr[9:1], 1'b0}]};
    case (op)
      rv32i_types_pkg::LB:  return {{24{b[7]}}, b};
      rv32i_types_pkg::LBU: return {24'h0, b};
      rv32i_types_pkg::LH:  return {{16{h[15]}}, h};
      rv32i_types_pkg::LHU: return {16'h0, h};
      default:              return w;
    endcase
  endfunction

  task automatic model_write(logic [31:0] addr, rv32i_types_pkg::load_t op, logic [31:0] d);
    case (op)
      rv32i_types_pkg::SB: model_mem[addr[9:0]] = d[7:0];
      rv32i_types_pkg::SH: begin
        model_mem[{addr[9:1], 1'b0}] = d[7:0];
        model_mem[{addr[9:1], 1'b1}] = d[15:8];
      end
      default: begin
        for (int i = 0; i < 4; i++) model_mem[{addr[9:2], 2'(i)}] = d[8*i +: 8];
      end
    endcase
  endtask

  // ########################################
  // Checks
  // ########################################

  task automatic check_load(logic [rv32i_types_pkg::xlen-1:0] got,
                            logic [rv32i_types_pkg::xlen-1:0] exp,
                            rv32i_types_pkg::load_t op);
    if (got !== exp) begin
      data_errors++;
      $display("ERROR @%0t: %s returned %h, expected %h", $time, op.name(), got, exp);
    end
  endtask

  task automatic check_fault(logic [rv32i_types_pkg::xlen-1:0] got,
                             logic [rv32i_types_pkg::xlen-1:0] exp);
    if (got !== exp) begin
      data_errors++;
      $display("ERROR @%0t: fault_addr is %h, expected %h", $time, got, exp);
    end
  endtask

  // Compares the response pulses with the oldest expectation.
  task automatic check_cycle();
    int                               kind;
    logic [rv32i_types_pkg::xlen-1:0] val;
    rv32i_types_pkg::load_t           op;
    kind = kind_q.pop_front();
    val  = val_q.pop_front();
    op   = op_q.pop_front();
    if (kind == kind_load) begin
      if (load_valid !== 1'b1) begin
        pulse_errors++;
        $display("The load_valid pulse for a %s is missing at %0t", op.name(), $time);
      end else begin
        check_load(load_data, val, op);
      end
    end else if (load_valid !== 1'b0) begin
      pulse_errors++;
      $display("An unexpected load_valid pulse appeared at %0t", $time);
    end
    if (kind == kind_fault) begin
      if (fault !== 1'b1) begin
        pulse_errors++;
        $display("The fault pulse for a misaligned %s is missing at %0t", op.name(), $time);
      end else begin
        check_fault(fault_addr, val);
      end
    end else if (fault !== 1'b0) begin
      pulse_errors++;
      $display("An unexpected fault pulse appeared at %0t", $time);
    end
  endtask

  // ########################################
  // Stimulus
  // ########################################

  // Drives one cycle on the falling edge and records what should follow.
  task automatic issue(logic r, logic [31:0] addr, rv32i_types_pkg::load_t op, logic [31:0] sd);
    logic [31:0] a;
    @(negedge clk);
    if (kind_q.size() > 0) check_cycle();
    a          = $urandom();
    req        = r;
    port_a     = a;
    port_b     = addr - a;
    load_type  = op;
    store_data = sd;
    val_q.push_back(addr);
    op_q.push_back(op);
    if (!r) begin
      kind_q.push_back(kind_none);
    end else if (is_mal(op, addr[1:0])) begin
      kind_q.push_back(kind_fault);
    end else if (is_load_op(op)) begin
      kind_q.push_back(kind_load);
      val_q[$] = model_read(addr, op);
    end else begin
      // An accepted store updates the model and gives no response.
      model_write(addr, op, sd);
      kind_q.push_back(kind_none);
    end
  endtask

  // Random target inside a 16-word window with random bits above bit 9.
  task automatic pick_request(output logic [31:0] addr, output rv32i_types_pkg::load_t op);
    logic [1:0] off;
    if ($urandom_range(0, 7) == 0) begin
      case ($urandom_range(0, 4))
        0: op = rv32i_types_pkg::LH;
        1: op = rv32i_types_pkg::LHU;
        2: op = rv32i_types_pkg::SH;
        3: op = rv32i_types_pkg::LW;
        default: op = rv32i_types_pkg::SW;
      endcase
      off = is_mal(op, 2'b10) ? 2'($urandom_range(1, 3)) : 2'($urandom_range(0, 1) * 2 + 1);
    end else begin
      op  = rv32i_types_pkg::load_t'(3'($urandom_range(0, 7)));
      off = 2'($urandom_range(0, 3));
      if (is_mal(op, 2'b01)) off[0] = 1'b0;
      if (is_mal(op, 2'b10)) off = 2'b00;
    end
    addr = ($urandom() & 32'hFFFF_FC00) | (32'h200 + $urandom_range(0, 15) * 4 + off);
  endtask

  initial begin
    logic [31:0]            addr;
    rv32i_types_pkg::load_t op;
    data_errors  = 0;
    pulse_errors = 0;
    void'($urandom(93));
    req        = 1'b0;
    port_a     = '0;
    port_b     = '0;
    load_type  = rv32i_types_pkg::LB;
    store_data = '0;
    wait (rst_n === 1'b1);
    // Quiet cycles first: both pulses must stay low out of reset.
    repeat (3) issue(1'b0, 32'h0, rv32i_types_pkg::LB, 32'h0);
    // Fill the window so that no load reads an unwritten byte.
    for (int i = 0; i < n_init; i++) begin
      issue(1'b1, ($urandom() & 32'hFFFF_FC00) | (32'h200 + i * 4), rv32i_types_pkg::SW,
            $urandom());
    end
    for (int i = 0; i < n_rand; i++) begin
      if ($urandom_range(0, 5) == 0) begin
        issue(1'b0, $urandom(), rv32i_types_pkg::load_t'(3'($urandom_range(0, 7))), $urandom());
      end else begin
        pick_request(addr, op);
        issue(1'b1, addr, op, $urandom());
      end
    end
    issue(1'b0, 32'h0, rv32i_types_pkg::LB, 32'h0);
    @(negedge clk);
    while (kind_q.size() > 0) check_cycle();
    $display("Summary: %0d data errors, %0d pulse errors", data_errors, pulse_errors);
    if (data_errors + pulse_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Ends a stuck run well after the last request should have finished.
  initial begin
    #(timeout_ns);
    $display("The run timed out before all requests were checked");
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
source/rv32i_types_pkg.sv
source/agu.sv
source/store_align.sv
source/access_ctrl.sv
source/data_ram.sv
source/load_align.sv
source/lsu_top.sv
testbench/clk_gen.sv
testbench/lsu_tb.sv
